// File: design/cache_pkg.sv
package cache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache storage types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one data word held in a cache block.
    typedef logic [31:0] data_word_t;

    // status bits kept per block.
    // dirty only means something while valid is set.
    typedef struct packed {
        logic valid;
        logic dirty;
    } status_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // array enables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one bit per array touched in a cycle.
    // all three set together on a full lookup or a metadata write.
    typedef struct packed {
        logic tag;
        logic status;
        logic data;
    } array_enable_t;

endpackage : cache_pkg

// File: design/mem_bus_pkg.sv
package mem_bus_pkg;

    // byte address on the external bus, always word aligned.
    typedef logic [31:0] bus_addr_t;

    // data word on the external bus.
    typedef logic [31:0] bus_word_t;

    // kind of a queued bus request.
    typedef enum logic {
        BUS_LOAD  = 1'b0,
        BUS_STORE = 1'b1
    } bus_kind_t;

endpackage : mem_bus_pkg

// File: design/load_controller.sv
`timescale 1ns/1ps

module load_controller #(
    parameter int OFFSET = 2,
    parameter int INDEX = 6,
    localparam int TAG = 30 - INDEX - OFFSET
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic stall_i,
    input  logic invalidate_i,
    // load unit side.
    input  logic request_i,
    input  logic [31:0] address_i,
    output cache_pkg::data_word_t data_o,
    output logic valid_o,
    output logic busy_o,
    // memory load channel.
    output logic load_request_o,
    output logic [31:0] load_address_o,
    input  logic load_valid_i,
    input  cache_pkg::data_word_t load_data_i,
    // memory store channel.
    output logic store_request_o,
    output logic [31:0] store_address_o,
    output cache_pkg::data_word_t store_data_o,
    // cache arrays.
    input  logic cache_hit_i,
    input  logic [TAG-1:0] cache_tag_i,
    input  logic cache_dirty_i,
    output cache_pkg::status_t cache_status_o,
    output logic [31:0] cache_address_o,
    input  cache_pkg::data_word_t cache_data_i,
    output cache_pkg::data_word_t cache_data_o,
    output cache_pkg::array_enable_t cache_read_o,
    output cache_pkg::array_enable_t cache_write_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address view
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [TAG-1:0] tag;
        logic [INDEX-1:0] index;
        logic [OFFSET-1:0] offset;
        logic [1:0] byte_sel;
    } addr_fields_t;

    // same word, raw or split into its cache fields.
    typedef union packed {
        logic [31:0] raw;
        addr_fields_t fields;
    } addr_view_t;

    // builds the byte address of one word of a block.
    function automatic logic [31:0] word_address(
        input logic [TAG-1:0] tag,
        input logic [INDEX-1:0] index,
        input logic [OFFSET-1:0] word
    );
        addr_view_t view;
        view.fields.tag = tag;
        view.fields.index = index;
        view.fields.offset = word;
        view.fields.byte_sel = 2'b00;
        return view.raw;
    endfunction

    typedef enum logic [2:0] {
        IDLE,
        OUTCOME,
        WRITE_BACK,
        ALLOCATION_REQ,
        ALLOCATE
    } state_t;

    state_t state_q, state_d;
    logic force_state, advance;
    logic [OFFSET:0] count_q, count_d;
    logic [OFFSET-1:0] fill_q, wb_word;
    logic refill_phase, fill_en, invalidate_pending, valid_d;
    addr_view_t addr_q;
    cache_pkg::data_word_t req_word_q, req_word_d, data_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // stall freezes state and counter, except in idle or on a forced exit.
    assign advance = (state_q == IDLE) | force_state | !stall_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else if (advance) begin
            state_q <= state_d;
            count_q <= count_d;
        end
    end

    // refill words arrive in order, counted apart from the requests.
    assign refill_phase = (state_q == ALLOCATION_REQ) | (state_q == ALLOCATE);
    assign fill_en = refill_phase & load_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fill_q <= '0;
            invalidate_pending <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_d;
            if (state_q == IDLE) begin
                fill_q <= '0;
                invalidate_pending <= 1'b0;
            end else begin
                if (fill_en) begin
                    fill_q <= fill_q + 1'b1;
                end
                if (invalidate_i) begin
                    invalidate_pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && request_i) begin
            addr_q.raw <= address_i;
        end
        if (valid_d) begin
            data_o <= data_d;
        end
        req_word_q <= req_word_d;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fsm
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign busy_o = state_q != IDLE;

    // data read last cycle belongs to the word before the counter.
    assign wb_word = count_q[OFFSET-1:0] - 1'b1;
    assign store_address_o = word_address(cache_tag_i, addr_q.fields.index, wb_word);
    assign store_data_o = cache_data_i;

    // refilled block is valid and clean.
    assign cache_status_o.valid = 1'b1;
    assign cache_status_o.dirty = 1'b0;

    always_comb begin
        state_d = state_q;
        count_d = count_q;
        force_state = 1'b0;
        req_word_d = req_word_q;
        data_d = cache_data_i;
        valid_d = 1'b0;
        load_request_o = 1'b0;
        load_address_o = word_address(addr_q.fields.tag, addr_q.fields.index,
                                      count_q[OFFSET-1:0]);
        store_request_o = 1'b0;
        cache_read_o = '0;
        cache_write_o = '0;
        cache_address_o = word_address(addr_q.fields.tag, addr_q.fields.index, fill_q);
        cache_data_o = load_data_i;

        case (state_q)
            // full lookup on the incoming address.
            IDLE: begin
                cache_address_o = address_i;
                count_d = '0;
                if (request_i) begin
                    cache_read_o = '1;
                    state_d = OUTCOME;
                end
            end

            // lookup result is registered now.
            OUTCOME: begin
                if (cache_hit_i) begin
                    force_state = 1'b1;
                    state_d = IDLE;
                    valid_d = !invalidate_i;
                end else if (invalidate_i) begin
                    force_state = 1'b1;
                    state_d = IDLE;
                end else if (cache_dirty_i) begin
                    // victim word 0 first.
                    cache_read_o.data = !stall_i;
                    cache_address_o = word_address(cache_tag_i, addr_q.fields.index, '0);
                    count_d = (OFFSET + 1)'(1);
                    state_d = WRITE_BACK;
                end else begin
                    state_d = ALLOCATION_REQ;
                end
            end

            // read word n while storing word n-1.
            WRITE_BACK: begin
                store_request_o = !stall_i;
                if (!count_q[OFFSET]) begin
                    cache_read_o.data = !stall_i;
                    cache_address_o = word_address(cache_tag_i, addr_q.fields.index,
                                                   count_q[OFFSET-1:0]);
                    count_d = count_q + 1'b1;
                end else begin
                    // block fully written back, victim stays consistent.
                    count_d = '0;
                    state_d = (invalidate_i | invalidate_pending) ? IDLE : ALLOCATION_REQ;
                end
            end

            // one load per cycle, block base first.
            ALLOCATION_REQ: begin
                if (!count_q[OFFSET]) begin
                    load_request_o = !stall_i;
                    count_d = count_q + 1'b1;
                end else begin
                    state_d = ALLOCATE;
                end
            end

            // allocate only waits for the rest of the block.
            default: ;
        endcase

        // responses may already arrive while loads are still going out.
        if (fill_en) begin
            cache_write_o.data = 1'b1;
            if (fill_q == addr_q.fields.offset) begin
                req_word_d = load_data_i;
            end
            if (fill_q == '1) begin
                // tag and status only once the whole block is in.
                cache_write_o = '1;
                data_d = (addr_q.fields.offset == '1) ? load_data_i : req_word_q;
                valid_d = !(invalidate_i | invalidate_pending);
                force_state = 1'b1;
                state_d = IDLE;
            end
        end
    end

endmodule : load_controller

// File: design/cache_memory.sv
`timescale 1ns/1ps

module cache_memory #(
    parameter int OFFSET = 2,
    parameter int INDEX = 6,
    localparam int TAG = 30 - INDEX - OFFSET
) (
    input  logic clk_i,
    input  logic rst_n_i,
    // controller port.
    input  logic [31:0] cache_address_i,
    input  cache_pkg::array_enable_t cache_read_i,
    input  cache_pkg::array_enable_t cache_write_i,
    input  cache_pkg::status_t cache_status_i,
    input  cache_pkg::data_word_t cache_data_i,
    output logic cache_hit_o,
    output logic [TAG-1:0] cache_tag_o,
    output logic cache_dirty_o,
    output cache_pkg::data_word_t cache_data_o,
    // cpu write-hit port.
    input  logic write_i,
    input  logic [31:0] write_address_i,
    input  cache_pkg::data_word_t write_data_i,
    output logic init_busy_o
);

    localparam int SETS = 2 ** INDEX;
    localparam int WORDS = 2 ** (INDEX + OFFSET);

    logic [TAG-1:0] tag_mem [SETS];
    cache_pkg::status_t status_mem [SETS];
    cache_pkg::data_word_t data_mem [WORDS];

    logic [TAG-1:0] req_tag, wr_tag, cmp_tag_q;
    logic [INDEX-1:0] req_index, wr_index, init_idx_q;
    logic [INDEX+OFFSET-1:0] req_word, wr_word;
    cache_pkg::status_t status_q;
    logic wr_hit;

    // field split of both addresses.
    assign req_tag = cache_address_i[31 -: TAG];
    assign req_index = cache_address_i[OFFSET+2 +: INDEX];
    assign req_word = cache_address_i[2 +: INDEX+OFFSET];
    assign wr_tag = write_address_i[31 -: TAG];
    assign wr_index = write_address_i[OFFSET+2 +: INDEX];
    assign wr_word = write_address_i[2 +: INDEX+OFFSET];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered reads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // each array keeps its last read while its enable is low.
    always_ff @(posedge clk_i) begin
        if (cache_read_i.tag) begin
            cache_tag_o <= tag_mem[req_index];
            cmp_tag_q <= req_tag;
        end
        if (cache_read_i.status) begin
            status_q <= status_mem[req_index];
        end
        if (cache_read_i.data) begin
            cache_data_o <= data_mem[req_word];
        end
    end

    assign cache_hit_o = status_q.valid && (cache_tag_o == cmp_tag_q);
    assign cache_dirty_o = status_q.valid & status_q.dirty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cpu write lands only on a valid tag match, and yields to the controller.
    assign wr_hit = write_i & !init_busy_o & (cache_write_i == '0)
                  & status_mem[wr_index].valid & (tag_mem[wr_index] == wr_tag);

    always_ff @(posedge clk_i) begin
        if (cache_write_i.tag) begin
            tag_mem[req_index] <= req_tag;
        end
        if (cache_write_i.data) begin
            data_mem[req_word] <= cache_data_i;
        end else if (wr_hit) begin
            data_mem[wr_word] <= write_data_i;
        end
    end

    // valid sweep first, one set per cycle.
    always_ff @(posedge clk_i) begin
        if (init_busy_o) begin
            status_mem[init_idx_q] <= '0;
        end else if (cache_write_i.status) begin
            status_mem[req_index] <= cache_status_i;
        end else if (wr_hit) begin
            status_mem[wr_index].dirty <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            init_idx_q <= '0;
            init_busy_o <= 1'b1;
        end else if (init_busy_o) begin
            init_idx_q <= init_idx_q + 1'b1;
            if (init_idx_q == '1) begin
                init_busy_o <= 1'b0;
            end
        end
    end

endmodule : cache_memory

// File: design/memory_port.sv
`timescale 1ns/1ps

module memory_port #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic clk_i,
    input  logic rst_n_i,
    // controller channels.
    input  logic load_request_i,
    input  mem_bus_pkg::bus_addr_t load_address_i,
    input  logic store_request_i,
    input  mem_bus_pkg::bus_addr_t store_address_i,
    input  cache_pkg::data_word_t store_data_i,
    output logic load_valid_o,
    output cache_pkg::data_word_t load_data_o,
    // external word bus.
    output logic mem_req_o,
    output logic mem_we_o,
    output mem_bus_pkg::bus_addr_t mem_addr_o,
    output mem_bus_pkg::bus_word_t mem_wdata_o,
    input  logic mem_rvalid_i,
    input  mem_bus_pkg::bus_word_t mem_rdata_i
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef struct packed {
        mem_bus_pkg::bus_kind_t kind;
        mem_bus_pkg::bus_addr_t addr;
        cache_pkg::data_word_t data;
    } entry_t;

    entry_t queue_q [QUEUE_DEPTH];
    entry_t head, store_entry, load_entry;
    logic [PTR_W-1:0] head_q, tail_q, tail_next;
    logic [PTR_W:0] count_q;
    logic [1:0] push_cnt;
    logic pop;

    assign store_entry = '{kind: mem_bus_pkg::BUS_STORE, addr: store_address_i,
                           data: store_data_i};
    assign load_entry = '{kind: mem_bus_pkg::BUS_LOAD, addr: load_address_i, data: '0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign push_cnt = {1'b0, store_request_i} + {1'b0, load_request_i};
    assign tail_next = tail_q + 1'b1;
    assign pop = count_q != '0;

    // store goes in ahead of a load from the same cycle.
    always_ff @(posedge clk_i) begin
        if (store_request_i) begin
            queue_q[tail_q] <= store_entry;
        end
        if (load_request_i) begin
            queue_q[store_request_i ? tail_next : tail_q] <= load_entry;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            tail_q <= tail_q + PTR_W'(push_cnt);
            head_q <= head_q + PTR_W'(pop);
            count_q <= count_q + (PTR_W + 1)'(push_cnt) - (PTR_W + 1)'(pop);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // head issues every cycle, memory never pushes back.
    assign head = queue_q[head_q];
    assign mem_req_o = pop;
    assign mem_we_o = head.kind == mem_bus_pkg::BUS_STORE;
    assign mem_addr_o = head.addr;
    assign mem_wdata_o = head.data;

    // in-order responses, straight to the controller.
    assign load_valid_o = mem_rvalid_i;
    assign load_data_o = mem_rdata_i;

endmodule : memory_port

// File: design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int OFFSET = 2,
    parameter int INDEX = 6,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic clk_i,
    input  logic rst_n_i,
    // load unit.
    input  logic request_i,
    input  logic [31:0] address_i,
    input  logic invalidate_i,
    input  logic stall_i,
    input  logic write_i,
    input  logic [31:0] write_address_i,
    input  cache_pkg::data_word_t write_data_i,
    output cache_pkg::data_word_t data_o,
    output logic valid_o,
    output logic busy_o,
    // external memory.
    output logic mem_req_o,
    output logic mem_we_o,
    output mem_bus_pkg::bus_addr_t mem_addr_o,
    output mem_bus_pkg::bus_word_t mem_wdata_o,
    input  logic mem_rvalid_i,
    input  mem_bus_pkg::bus_word_t mem_rdata_i
);

    localparam int TAG = 30 - INDEX - OFFSET;

    // controller to arrays.
    logic [31:0] cache_address;
    cache_pkg::array_enable_t cache_read, cache_write;
    cache_pkg::status_t cache_status_out;
    cache_pkg::data_word_t cache_data_out, cache_data_in;
    logic cache_hit, cache_dirty;
    logic [TAG-1:0] cache_tag;

    // controller to memory port.
    logic load_request, load_valid, store_request;
    mem_bus_pkg::bus_addr_t load_address, store_address;
    cache_pkg::data_word_t load_data, store_data;

    logic ctrl_busy, init_busy;

    // busy also covers the valid sweep after reset.
    assign busy_o = ctrl_busy | init_busy;

    load_controller #(
        .OFFSET(OFFSET),
        .INDEX(INDEX)
    ) u_load_controller (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .stall_i(stall_i),
        .invalidate_i(invalidate_i),
        .request_i(request_i),
        .address_i(address_i),
        .data_o(data_o),
        .valid_o(valid_o),
        .busy_o(ctrl_busy),
        .load_request_o(load_request),
        .load_address_o(load_address),
        .load_valid_i(load_valid),
        .load_data_i(load_data),
        .store_request_o(store_request),
        .store_address_o(store_address),
        .store_data_o(store_data),
        .cache_hit_i(cache_hit),
        .cache_tag_i(cache_tag),
        .cache_dirty_i(cache_dirty),
        .cache_status_o(cache_status_out),
        .cache_address_o(cache_address),
        .cache_data_i(cache_data_in),
        .cache_data_o(cache_data_out),
        .cache_read_o(cache_read),
        .cache_write_o(cache_write)
    );

    cache_memory #(
        .OFFSET(OFFSET),
        .INDEX(INDEX)
    ) u_cache_memory (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .cache_address_i(cache_address),
        .cache_read_i(cache_read),
        .cache_write_i(cache_write),
        .cache_status_i(cache_status_out),
        .cache_data_i(cache_data_out),
        .cache_hit_o(cache_hit),
        .cache_tag_o(cache_tag),
        .cache_dirty_o(cache_dirty),
        .cache_data_o(cache_data_in),
        .write_i(write_i),
        .write_address_i(write_address_i),
        .write_data_i(write_data_i),
        .init_busy_o(init_busy)
    );

    memory_port #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_memory_port (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .load_request_i(load_request),
        .load_address_i(load_address),
        .store_request_i(store_request),
        .store_address_i(store_address),
        .store_data_i(store_data),
        .load_valid_o(load_valid),
        .load_data_o(load_data),
        .mem_req_o(mem_req_o),
        .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_rdata_i(mem_rdata_i)
    );

endmodule : dcache_top

// File: tests/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts (
    input logic clk_i,
    input logic rst_n_i,
    input logic valid_i,
    input logic busy_i,
    input logic load_request_i,
    input logic store_request_i,
    input cache_pkg::array_enable_t cache_write_i
);

    logic loads_issued_q;

    // set by the first refill load of a miss.
    // cleared once the controller is idle again.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            loads_issued_q <= 1'b0;
        end else if (load_request_i) begin
            loads_issued_q <= 1'b1;
        end else if (!busy_i) begin
            loads_issued_q <= 1'b0;
        end
    end

    // a load is answered by a single pulse.
    valid_single_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) valid_i |=> !valid_i
    ) else $error("valid_o high in two consecutive cycles");

    // no memory traffic from an idle controller.
    idle_quiet: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !busy_i |-> !load_request_i && !store_request_i
    ) else $error("memory request issued while the controller is idle");

    // arrays written only after the miss has asked memory for its block.
    write_in_refill: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cache_write_i != '0 |-> loads_issued_q
    ) else $error("cache_write_o active outside allocation");

endmodule : dcache_asserts

bind load_controller dcache_asserts u_dcache_asserts (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(valid_o),
    .busy_i(busy_o),
    .load_request_i(load_request_o),
    .store_request_i(store_request_o),
    .cache_write_i(cache_write_o)
);

// File: tests/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int OFFSET = 2;
    localparam int INDEX = 6;
    localparam int SETS = 2 ** INDEX;
    localparam int TAG_LSB = OFFSET + INDEX + 2;
    localparam int MAX_STEPS = 40;
    localparam int STEP_LIMIT = 150;

    // step kinds.
    localparam logic [2:0] OP_LOAD = 3'd0;
    localparam logic [2:0] OP_WRITE = 3'd1;
    localparam logic [2:0] OP_MEMCHK = 3'd2;
    localparam logic [2:0] OP_INVAL = 3'd3;
    localparam logic [2:0] OP_STALL = 3'd4;

    logic clk_i = 1'b0;
    logic rst_n_i, request_i, invalidate_i, stall_i, write_i;
    logic [31:0] address_i, write_address_i;
    cache_pkg::data_word_t write_data_i, data_o;
    logic valid_o, busy_o, mem_req_o, mem_we_o, mem_rvalid_i;
    mem_bus_pkg::bus_addr_t mem_addr_o;
    mem_bus_pkg::bus_word_t mem_wdata_o, mem_rdata_i;

    // stimulus table, latency column is zero where a miss is expected.
    logic [2:0] step_op [MAX_STEPS];
    logic [31:0] step_addr [MAX_STEPS];
    logic [31:0] step_data [MAX_STEPS];
    int step_lat [MAX_STEPS];
    int step_count, mismatches, failures;

    // external memory contents and expected contents, as written words.
    logic [31:0] mem_addr_q [$];
    logic [31:0] mem_data_q [$];
    logic [31:0] arch_addr_q [$];
    logic [31:0] arch_data_q [$];
    logic pipe_valid;
    logic [31:0] pipe_data;

    // residency of the reference cache.
    logic ref_valid [SETS];
    logic [31:0] ref_tag [SETS];

    always #5 clk_i = ~clk_i;

    dcache_top #(
        .OFFSET(OFFSET),
        .INDEX(INDEX),
        .QUEUE_DEPTH(8)
    ) dut_i (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .request_i(request_i),
        .address_i(address_i),
        .invalidate_i(invalidate_i),
        .stall_i(stall_i),
        .write_i(write_i),
        .write_address_i(write_address_i),
        .write_data_i(write_data_i),
        .data_o(data_o),
        .valid_o(valid_o),
        .busy_o(busy_o),
        .mem_req_o(mem_req_o),
        .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_rdata_i(mem_rdata_i)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // untouched words hold a pattern of their own address.
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // newest write wins.
    function automatic logic [31:0] mem_value(input logic [31:0] addr);
        for (int i = mem_addr_q.size() - 1; i >= 0; i--) begin
            if (mem_addr_q[i] == addr) begin
                return mem_data_q[i];
            end
        end
        return initial_word(addr);
    endfunction

    function automatic logic [31:0] arch_value(input logic [31:0] addr);
        for (int i = arch_addr_q.size() - 1; i >= 0; i--) begin
            if (arch_addr_q[i] == addr) begin
                return arch_data_q[i];
            end
        end
        return initial_word(addr);
    endfunction

    // load data comes back two cycles after the request cycle.
    always @(posedge clk_i) begin : memory_model
        logic issue_valid;
        logic [31:0] issue_data;
        issue_valid = (mem_req_o === 1'b1) && (mem_we_o === 1'b0);
        issue_data = mem_value(mem_addr_o);
        if (mem_req_o === 1'b1 && mem_we_o === 1'b1) begin
            mem_addr_q.push_back(mem_addr_o);
            mem_data_q.push_back(mem_wdata_o);
        end
        #1;
        mem_rvalid_i = pipe_valid;
        mem_rdata_i = pipe_data;
        pipe_valid = issue_valid;
        pipe_data = issue_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic add_step(input logic [2:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input int lat);
        step_op[step_count] = op;
        step_addr[step_count] = addr;
        step_data[step_count] = data;
        step_lat[step_count] = lat;
        step_count++;
    endtask

    task automatic build_table();
        logic [31:0] raddr;
        // cold miss, then hits on the same block.
        add_step(OP_LOAD, 32'h0000_1040, '0, 0);
        add_step(OP_LOAD, 32'h0000_1040, '0, 2);
        add_step(OP_LOAD, 32'h0000_104C, '0, 2);
        // refill asked for by the last word.
        add_step(OP_LOAD, 32'h0000_208C, '0, 0);
        add_step(OP_LOAD, 32'h0000_2080, '0, 2);
        add_step(OP_LOAD, 32'h0000_2084, '0, 2);
        add_step(OP_LOAD, 32'h0000_2088, '0, 2);
        add_step(OP_WRITE, 32'h0000_1044, 32'hDEAD_BEEF, 0);
        add_step(OP_LOAD, 32'h0000_1044, '0, 2);
        // write miss, dropped.
        add_step(OP_WRITE, 32'h0000_3000, 32'hBAD0_0001, 0);
        add_step(OP_LOAD, 32'h0000_3000, '0, 0);
        // same set, other tag, so the dirty block goes back.
        add_step(OP_LOAD, 32'h0000_5040, '0, 0);
        add_step(OP_MEMCHK, 32'h0000_1044, '0, 0);
        add_step(OP_LOAD, 32'h0000_1044, '0, 0);
        // abandoned misses, clean victim then dirty victim.
        add_step(OP_INVAL, 32'h0000_7080, '0, 0);
        add_step(OP_LOAD, 32'h0000_7084, '0, 0);
        add_step(OP_WRITE, 32'h0000_1048, 32'hCAFE_0005, 0);
        add_step(OP_INVAL, 32'h0000_9040, '0, 0);
        add_step(OP_LOAD, 32'h0000_1048, '0, 0);
        // stall inside a refill, then inside a write-back.
        add_step(OP_STALL, 32'h0000_B0C0, '0, 0);
        add_step(OP_LOAD, 32'h0000_B0C8, '0, 2);
        add_step(OP_WRITE, 32'h0000_B0C4, 32'h5A5A_0006, 0);
        add_step(OP_STALL, 32'h0000_D0C0, '0, 0);
        add_step(OP_MEMCHK, 32'h0000_B0C4, '0, 0);
        add_step(OP_LOAD, 32'h0000_B0C4, '0, 0);
        // random block, then a repeat that must hit.
        for (int i = 0; i < 4; i++) begin
            raddr = $urandom & 32'hFFFF_FFFC;
            add_step(OP_LOAD, raddr, '0, 0);
            add_step(OP_LOAD, raddr, '0, 2);
        end
    endtask

    task automatic run_step(input int n);
        logic [2:0] op;
        logic [31:0] addr, expected, got;
        logic seen, done;
        int set_idx, cycles;
        op = step_op[n];
        addr = step_addr[n];
        set_idx = int'(addr[OFFSET+2 +: INDEX]);
        expected = arch_value(addr);
        if (op == OP_WRITE) begin
            write_i = 1'b1;
            write_address_i = addr;
            write_data_i = step_data[n];
            @(posedge clk_i);
            #1;
            write_i = 1'b0;
            // only a resident block takes the write.
            if (ref_valid[set_idx] && ref_tag[set_idx] == (addr >> TAG_LSB)) begin
                arch_addr_q.push_back(addr);
                arch_data_q.push_back(step_data[n]);
            end
        end else if (op == OP_MEMCHK) begin
            got = mem_value(addr);
            if (got !== expected) begin
                $display("MISMATCH mem[%h]: expected %h got %h", addr, expected, got);
                mismatches++;
            end
        end else begin
            request_i = 1'b1;
            address_i = addr;
            cycles = 0;
            seen = 1'b0;
            done = 1'b0;
            got = '0;
            while (!done) begin
                @(posedge clk_i);
                #1;
                cycles++;
                request_i = 1'b0;
                if (op == OP_INVAL) begin
                    invalidate_i = (cycles == 2);
                end
                if (op == OP_STALL) begin
                    stall_i = (cycles >= 3) && (cycles < 8);
                end
                if (valid_o) begin
                    seen = 1'b1;
                    got = data_o;
                end
                done = (op == OP_INVAL) ? !busy_o : seen;
                if (cycles >= STEP_LIMIT) begin
                    done = 1'b1;
                end
            end
            invalidate_i = 1'b0;
            stall_i = 1'b0;
            if (op == OP_INVAL) begin
                if (busy_o) begin
                    $display("ERROR: busy_o still high after invalidate at %h", addr);
                    failures++;
                end
                if (seen) begin
                    $display("ERROR: valid_o pulsed for invalidated load at %h", addr);
                    failures++;
                end
                // residency unknown after an abandoned miss.
                ref_valid[set_idx] = 1'b0;
            end else if (!seen) begin
                $display("ERROR: no valid_o for load at %h", addr);
                failures++;
            end else begin
                if (got !== expected) begin
                    $display("MISMATCH data_o addr %h: expected %h got %h", addr, expected, got);
                    mismatches++;
                end
                if (step_lat[n] != 0 && cycles != step_lat[n]) begin
                    $display("MISMATCH valid_o latency addr %h: expected %h got %h",
                             addr, step_lat[n], cycles);
                    mismatches++;
                end
                ref_valid[set_idx] = 1'b1;
                ref_tag[set_idx] = addr >> TAG_LSB;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int cycles;
        rst_n_i = 1'b0;
        request_i = 1'b0;
        address_i = '0;
        invalidate_i = 1'b0;
        stall_i = 1'b0;
        write_i = 1'b0;
        write_address_i = '0;
        write_data_i = '0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        pipe_valid = 1'b0;
        pipe_data = '0;
        mismatches = 0;
        failures = 0;
        step_count = 0;
        for (int s = 0; s < SETS; s++) begin
            ref_valid[s] = 1'b0;
            ref_tag[s] = '0;
        end
        void'($urandom(91437));
        build_table();
        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        // valid bits are swept clear first.
        cycles = 0;
        while (busy_o !== 1'b0 && cycles < 200) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (busy_o !== 1'b0) begin
            $display("ERROR: busy_o still high %0d cycles after reset", cycles);
            failures++;
        end
        for (int n = 0; n < step_count; n++) begin
            run_step(n);
        end
        $display("steps %0d, mismatches %0d, other errors %0d", step_count, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table once it is built.
    initial begin
        int limit;
        #1;
        limit = step_count * 200 + 100;
        repeat (limit) @(posedge clk_i);
        $display("ERROR: watchdog expired after %0d cycles", limit);
        $display("steps %0d, mismatches %0d, other errors %0d", step_count, mismatches, failures);
        $display("TEST FAILED");
        $finish;
    end

endmodule : dcache_tb

// File: dcache.f
design/cache_pkg.sv
design/mem_bus_pkg.sv
design/load_controller.sv
design/cache_memory.sv
design/memory_port.sv
design/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - design/cache_pkg.sv
  - design/mem_bus_pkg.sv
  - design/load_controller.sv
  - design/cache_memory.sv
  - design/memory_port.sv
  - design/dcache_top.sv
  - target: test
    files:
      - tests/dcache_asserts.sv
      - tests/dcache_tb.sv
